/* hw/maxpool_pkg.sv */
package maxpool_pkg;

    // pixel format, signed Q15.16
    localparam int VALUE_BITS = 32;
    localparam int CHANNELS   = 3;    // independent feature maps, pooled in lock step

    // image and window geometry
    localparam int IMG_WIDTH  = 5;    // pixels per input row
    localparam int POOL_SIZE  = 2;    // window edge, also rows per band
    localparam int OUT_WIDTH  = IMG_WIDTH / POOL_SIZE;   // whole windows per row
    localparam int USED_WIDTH = OUT_WIDTH * POOL_SIZE;   // columns past this are dropped

    // window floor: 1 starts at zero (relu), 0 starts at the most negative value
    localparam bit RELU = 1'b0;

    // counter widths, geometry assumes POOL_SIZE >= 2 and OUT_WIDTH >= 2
    localparam int COL_BITS = $clog2(OUT_WIDTH);   // line ram address
    localparam int PIX_BITS = $clog2(IMG_WIDTH);   // input column 0 .. IMG_WIDTH-1
    localparam int ROW_BITS = $clog2(POOL_SIZE);   // row in band 0 .. POOL_SIZE-1

    typedef logic signed [VALUE_BITS-1:0] pixel_t;   // one channel of one pixel

endpackage

/* hw/pool_lane_if.sv */
// commands from the sequencer, fanned out to every channel lane
interface pool_lane_if;

    logic [maxpool_pkg::COL_BITS-1:0] rd_addr;   // line ram read column, same for all lanes
    logic                             load_base;       // reload running max for a new window
    logic                             base_from_ram;   // 0 on first row of band -> use floor
    logic                             take_pixel;      // fold i_data into running max
    logic                             wr_en;           // store running max
    logic [maxpool_pkg::COL_BITS-1:0] wr_addr;   // column being stored

    modport ctrl (
        output rd_addr,
        output load_base,
        output base_from_ram,
        output take_pixel,
        output wr_en,
        output wr_addr
    );

    modport lane (
        input rd_addr,
        input load_base,
        input base_from_ram,
        input take_pixel,
        input wr_en,
        input wr_addr
    );

endinterface

/* hw/line_ram.sv */
// simple dual port ram, one write port and one registered read port
module line_ram #(
    parameter int DEPTH = 2,   // words, one per output column
    parameter int WIDTH = 32   // bits per word
) (
    input  logic                     clk,
    input  logic                     i_wr_en,
    input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
    input  logic [WIDTH-1:0]         i_wr_data,
    input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
    output logic [WIDTH-1:0]         o_rd_data   // valid one cycle after i_rd_addr
);

    logic [WIDTH-1:0] mem [DEPTH];   // no reset, first band row never reads it

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];   // read-before-write on address collision
    end

endmodule

/* hw/pool_ctrl.sv */
// sequencer shared by all channel lanes
// per window: read -> base -> take POOL_SIZE pixels -> write
// per band: POOL_SIZE rows, then prime the read port and stream OUT_WIDTH results
module pool_ctrl (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_valid,
    input  logic      i_last,
    input  logic      o_ready,
    output logic      i_ready,
    output logic      o_valid,
    output logic      o_last,
    pool_lane_if.ctrl lane
);

    enum logic [2:0] {
        ST_READ,    // present column address to the line ram
        ST_BASE,    // ram word is out, lanes load their running max
        ST_TAKE,    // accept the POOL_SIZE pixels of this window row
        ST_WRITE,   // store running max, step to next column
        ST_SKIP,    // swallow trailing columns that do not fill a window
        ST_PRIME,   // read column 0 ahead of the output phase
        ST_OUT      // stream the band results
    } state_q, state_d;

    logic [maxpool_pkg::PIX_BITS-1:0] pix_q, pix_d;   // input column in current row
    logic [maxpool_pkg::ROW_BITS-1:0] win_q, win_d;   // pixels taken in current window
    logic [maxpool_pkg::COL_BITS-1:0] col_q, col_d;   // window column, output column in ST_OUT
    logic [maxpool_pkg::ROW_BITS-1:0] row_q, row_d;   // row in band
    logic                             got_last_q, got_last_d;   // band holds end of image
    logic                             in_xfer;    // input handshake fires
    logic                             out_xfer;   // output handshake fires
    logic                             last_col;   // on final output column
    logic                             row_done;   // final pixel of the row handled

    assign i_ready  = (state_q == ST_TAKE) || (state_q == ST_SKIP);   // low in output phase
    assign o_valid  = (state_q == ST_OUT);
    assign in_xfer  = i_valid && i_ready;
    assign out_xfer = o_valid && o_ready;
    assign last_col = (col_q == maxpool_pkg::OUT_WIDTH - 1);
    assign o_last   = o_valid && got_last_q && last_col;

    // lane commands, all decoded from the current state
    assign lane.load_base     = (state_q == ST_BASE);
    assign lane.base_from_ram = (row_q != '0);   // row 0 starts from the floor
    assign lane.take_pixel    = (state_q == ST_TAKE) && in_xfer;
    assign lane.wr_en         = (state_q == ST_WRITE);
    assign lane.wr_addr       = col_q;

    // read port address
    // held under back-pressure so the ram re-reads the same word and o_data stays put
    always_comb begin
        lane.rd_addr = col_q;
        if (out_xfer) begin
            lane.rd_addr = last_col ? '0 : col_q + 1'b1;   // fetch next result early
        end
    end

    always_comb begin
        state_d    = state_q;
        pix_d      = pix_q;
        win_d      = win_q;
        col_d      = col_q;
        row_d      = row_q;
        got_last_d = got_last_q;
        row_done   = 1'b0;

        // every accepted pixel counts, used or discarded
        if (in_xfer) begin
            pix_d = pix_q + 1'b1;
            if (i_last) begin
                got_last_d = 1'b1;   // results of this band close the image
            end
        end

        case (state_q)
            ST_READ:  state_d = ST_BASE;
            ST_BASE:  state_d = ST_TAKE;
            ST_TAKE: begin
                if (in_xfer) begin
                    win_d = win_q + 1'b1;
                    if (win_q == maxpool_pkg::POOL_SIZE - 1) begin
                        win_d   = '0;
                        state_d = ST_WRITE;
                    end
                end
            end
            ST_WRITE: begin
                col_d = col_q + 1'b1;
                if (!last_col) begin
                    state_d = ST_READ;   // next window in this row
                end else if (maxpool_pkg::USED_WIDTH < maxpool_pkg::IMG_WIDTH) begin
                    state_d = ST_SKIP;   // leftover columns still to drain
                end else begin
                    row_done = 1'b1;
                end
            end
            ST_SKIP: begin
                if (in_xfer && (pix_q == maxpool_pkg::IMG_WIDTH - 1)) begin
                    row_done = 1'b1;
                end
            end
            ST_PRIME: state_d = ST_OUT;   // column 0 word appears next cycle
            ST_OUT: begin
                if (out_xfer) begin
                    col_d = col_q + 1'b1;
                    if (last_col) begin   // band drained, back to input
                        col_d      = '0;
                        got_last_d = 1'b0;
                        state_d    = ST_READ;
                    end
                end
            end
            default: state_d = ST_READ;
        endcase

        // row wrap, band complete after POOL_SIZE rows
        if (row_done) begin
            pix_d = '0;
            col_d = '0;
            if (row_q == maxpool_pkg::POOL_SIZE - 1) begin
                row_d   = '0;
                state_d = ST_PRIME;
            end else begin
                row_d   = row_q + 1'b1;
                state_d = ST_READ;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= ST_READ;
            pix_q      <= '0;
            win_q      <= '0;
            col_q      <= '0;
            row_q      <= '0;
            got_last_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            pix_q      <= pix_d;
            win_q      <= win_d;
            col_q      <= col_d;
            row_q      <= row_d;
            got_last_q <= got_last_d;
        end
    end

endmodule

/* hw/pool_lane.sv */
// one channel: running max of the current window plus its line ram
// the ram keeps the partial max of each output column across the rows of a band
module pool_lane (
    input  logic                clk,
    input  maxpool_pkg::pixel_t i_data,   // pixel of this channel
    output maxpool_pkg::pixel_t o_data,   // pooled result during output phase
    pool_lane_if.lane           lane
);

    maxpool_pkg::pixel_t run_max_q;     // max of the window so far
    maxpool_pkg::pixel_t ram_rd_data;   // word at last rd_addr
    maxpool_pkg::pixel_t floor_val;     // starting value on row 0 of a band

    // zero under relu, else most negative Q15.16 value
    assign floor_val = maxpool_pkg::RELU ? '0 :
                       {1'b1, {(maxpool_pkg::VALUE_BITS - 1){1'b0}}};

    // updates one cycle after the command
    always_ff @(posedge clk) begin
        if (lane.load_base) begin
            run_max_q <= lane.base_from_ram ? ram_rd_data : floor_val;
        end else if (lane.take_pixel && (i_data > run_max_q)) begin
            run_max_q <= i_data;   // signed compare, pixel_t is signed
        end
    end

    line_ram #(
        .DEPTH (maxpool_pkg::OUT_WIDTH),
        .WIDTH (maxpool_pkg::VALUE_BITS)
    ) u_line_ram (
        .clk       (clk),
        .i_wr_en   (lane.wr_en),
        .i_wr_addr (lane.wr_addr),
        .i_wr_data (run_max_q),
        .i_rd_addr (lane.rd_addr),
        .o_rd_data (ram_rd_data)
    );

    // in output phase the read word is the finished window max
    assign o_data = ram_rd_data;

endmodule

/* hw/maxpool2d.sv */
// multi channel 2d max pooling, raster order in, one band of results out at a time
// one sequencer drives all lanes, so handshakes are common to every channel
module maxpool2d (
    input  logic                clk,
    input  logic                reset,

    // pixel stream in, one word per channel
    input  maxpool_pkg::pixel_t i_data [maxpool_pkg::CHANNELS],
    input  logic                i_valid,
    output logic                i_ready,
    input  logic                i_last,    // final pixel of the image

    // pooled stream out
    output maxpool_pkg::pixel_t o_data [maxpool_pkg::CHANNELS],
    output logic                o_valid,
    input  logic                o_ready,
    output logic                o_last     // final result of the image
);

    pool_lane_if lane_cmd ();   // sequencer to lanes

    pool_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .i_valid (i_valid),
        .i_last  (i_last),
        .o_ready (o_ready),
        .i_ready (i_ready),
        .o_valid (o_valid),
        .o_last  (o_last),
        .lane    (lane_cmd.ctrl)
    );

    // one lane per channel, all fed the same commands
    genvar ch;
    generate
        for (ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin : g_lane
            pool_lane u_lane (
                .clk    (clk),
                .i_data (i_data[ch]),
                .o_data (o_data[ch]),
                .lane   (lane_cmd.lane)
            );
        end
    endgenerate

endmodule

/* tb/maxpool2d_assert.sv */
// handshake rules of the pooling engine, bound into maxpool2d
module maxpool2d_assert (
    input logic                clk,
    input logic                reset,
    input logic                i_in_ready,     // dut i_ready
    input maxpool_pkg::pixel_t i_out_data [maxpool_pkg::CHANNELS],
    input logic                i_out_valid,
    input logic                i_out_ready,
    input logic                i_out_last
);

    logic [maxpool_pkg::CHANNELS*maxpool_pkg::VALUE_BITS-1:0] data_flat;   // all lanes in one word
    int unsigned fail_count = 0;   // read by the testbench at the end

    always_comb begin
        for (int ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin
            data_flat[ch*maxpool_pkg::VALUE_BITS +: maxpool_pkg::VALUE_BITS] = i_out_data[ch];
        end
    end

    // a stalled result must not change or vanish
    a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
        (i_out_valid && !i_out_ready) |=>
            (i_out_valid && $stable(data_flat) && $stable(i_out_last)))
        else begin
            fail_count++;
            $error("output changed while stalled by o_ready");
        end

    // input and output phases never overlap
    a_phase_excl: assert property (@(posedge clk) disable iff (reset)
        !(i_in_ready && i_out_valid))
        else begin
            fail_count++;
            $error("i_ready and o_valid high together");
        end

    a_last_valid: assert property (@(posedge clk) disable iff (reset)
        i_out_last |-> i_out_valid)   // o_last only qualifies a valid result
        else begin
            fail_count++;
            $error("o_last high without o_valid");
        end

endmodule

bind maxpool2d maxpool2d_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .i_in_ready  (i_ready),
    .i_out_data  (o_data),
    .i_out_valid (o_valid),
    .i_out_ready (o_ready),
    .i_out_last  (o_last)
);

/* tb/maxpool2d_checker.sv */
// scoreboard on the output handshake, expected results come from the testbench queue
module maxpool2d_checker (
    input logic                clk,
    input logic                reset,
    input maxpool_pkg::pixel_t i_out_data [maxpool_pkg::CHANNELS],
    input logic                i_out_valid,
    input logic                i_out_ready,
    input logic                i_out_last
);

    localparam int VB = maxpool_pkg::VALUE_BITS;

    logic [maxpool_pkg::CHANNELS*VB-1:0] exp_data_q [$];   // one entry per output column
    bit                                  exp_last_q [$];   // o_last expected with it
    logic [maxpool_pkg::CHANNELS*VB-1:0] exp_word;
    bit                                  exp_last;

    int unsigned test_checks  = 0;   // transfers compared in the running test
    int unsigned test_errors  = 0;
    int unsigned total_checks = 0;
    int unsigned total_errors = 0;
    int unsigned tests_run    = 0;
    int unsigned tests_failed = 0;

    task automatic expect_result(input logic [maxpool_pkg::CHANNELS*VB-1:0] data, input bit last);
        exp_data_q.push_back(data);
        exp_last_q.push_back(last);
    endtask

    function automatic int pending_count();
        return exp_data_q.size();
    endfunction

    // one line per test, leftovers in the queue count as a failure
    task automatic finish_test(input string name, input bit aborted);
        bit failed;
        failed = aborted || (test_errors != 0) || (exp_data_q.size() != 0);
        tests_run++;
        if (failed) begin
            tests_failed++;
        end
        total_checks += test_checks;
        total_errors += test_errors;
        $display("test %0s: %0d results checked, %0d errors, %0s",
                 name, test_checks, test_errors, failed ? "failed" : "passed");
        test_checks = 0;
        test_errors = 0;
        exp_data_q.delete();
        exp_last_q.delete();
    endtask

    // values sampled at the edge where the transfer happens
    always @(posedge clk) begin
        if (!reset && i_out_valid && i_out_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("output transfer at time %0t while no result was expected", $time);
                test_errors++;
            end else begin
                exp_word = exp_data_q.pop_front();
                exp_last = exp_last_q.pop_front();
                test_checks++;
                for (int ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin
                    if (i_out_data[ch] !== exp_word[ch*VB +: VB]) begin
                        $display("error: time %0t, o_data[%0d] expected %h, actual %h",
                                 $time, ch, exp_word[ch*VB +: VB], i_out_data[ch]);
                        test_errors++;
                    end
                end
                if (i_out_last !== exp_last) begin
                    $display("error: time %0t, o_last expected %0b, actual %0b",
                             $time, exp_last, i_out_last);
                    test_errors++;
                end
            end
        end
    end

endmodule

/* tb/tb_maxpool2d.sv */
// testbench top: reads test records, drives pixels with gaps, randomizes o_ready
module tb_maxpool2d;

    localparam int VB        = maxpool_pkg::VALUE_BITS;
    localparam int WORD_BITS = maxpool_pkg::CHANNELS * VB;   // one pixel, all channels
    localparam int TIMEOUT   = 2000;                          // cycles per wait

    logic                clk;
    logic                reset;
    maxpool_pkg::pixel_t i_data [maxpool_pkg::CHANNELS];
    logic                i_valid;
    logic                i_ready;
    logic                i_last;
    maxpool_pkg::pixel_t o_data [maxpool_pkg::CHANNELS];
    logic                o_valid;
    logic                o_ready;
    logic                o_last;

    logic [WORD_BITS-1:0] pix_q [$];        // pixels of the current test, raster order
    bit                   pix_last_q [$];   // i_last per pixel
    bit                   bp_on;            // random o_ready in this test
    bit                   timed_out;
    bit                   file_error;
    int                   fd;
    logic [63:0]          tag;              // record type of the next line
    logic [8*32-1:0]      test_name;
    logic [8*128-1:0]     line;             // rest of a comment line

    maxpool2d dut (
        .clk     (clk),
        .reset   (reset),
        .i_data  (i_data),
        .i_valid (i_valid),
        .i_ready (i_ready),
        .i_last  (i_last),
        .o_data  (o_data),
        .o_valid (o_valid),
        .o_ready (o_ready),
        .o_last  (o_last)
    );

    maxpool2d_checker u_chk (
        .clk         (clk),
        .reset       (reset),
        .i_out_data  (o_data),
        .i_out_valid (o_valid),
        .i_out_ready (o_ready),
        .i_out_last  (o_last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sink accepts about two cycles in three under back-pressure
    always @(posedge clk) begin
        o_ready <= bp_on ? (($urandom % 3) != 0) : 1'b1;
    end

    // one image row: IMG_WIDTH pixels of CHANNELS words, then the i_last flag
    task automatic read_input_row();
        logic [WORD_BITS-1:0] word;
        logic [VB-1:0]        val;
        int                   flag;
        for (int x = 0; x < maxpool_pkg::IMG_WIDTH; x++) begin
            for (int ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin
                void'($fscanf(fd, "%h", val));
                word[ch*VB +: VB] = val;
            end
            pix_q.push_back(word);
            pix_last_q.push_back(1'b0);
        end
        void'($fscanf(fd, "%d", flag));
        pix_last_q[pix_last_q.size()-1] = (flag != 0);   // final pixel of the image
    endtask

    // one band of results, the flag is o_last on the final column
    task automatic read_expected_row();
        logic [WORD_BITS-1:0] words [maxpool_pkg::OUT_WIDTH];
        logic [VB-1:0]        val;
        int                   flag;
        for (int col = 0; col < maxpool_pkg::OUT_WIDTH; col++) begin
            for (int ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin
                void'($fscanf(fd, "%h", val));
                words[col][ch*VB +: VB] = val;
            end
        end
        void'($fscanf(fd, "%d", flag));
        for (int col = 0; col < maxpool_pkg::OUT_WIDTH; col++) begin
            u_chk.expect_result(words[col], (col == maxpool_pkg::OUT_WIDTH - 1) && (flag != 0));
        end
    endtask

    // called on a rising edge, returns on the edge where the pixel is taken
    task automatic drive_pixel(input logic [WORD_BITS-1:0] word, input bit last);
        int cycles;
        int gaps;
        gaps = 0;
        while ((gaps < 3) && (($urandom % 4) == 0)) begin   // idle cycles before the pixel
            i_valid <= 1'b0;
            gaps++;
            @(posedge clk);
        end
        for (int ch = 0; ch < maxpool_pkg::CHANNELS; ch++) begin
            i_data[ch] <= word[ch*VB +: VB];
        end
        i_last  <= last;
        i_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!i_ready && (cycles < TIMEOUT));   // i_ready still holds its pre-edge value
        if (!i_ready) begin
            timed_out = 1'b1;
            $display("timeout: pixel not accepted within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic run_test();
        int cycles;
        while ((pix_q.size() != 0) && !timed_out) begin
            drive_pixel(pix_q.pop_front(), pix_last_q.pop_front());
        end
        i_valid <= 1'b0;
        i_last  <= 1'b0;
        cycles = 0;
        while ((u_chk.pending_count() != 0) && !timed_out) begin   // drain remaining bands
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
                $display("timeout: %0d expected results never left the DUT",
                         u_chk.pending_count());
            end
        end
        u_chk.finish_test($sformatf("%0s", test_name), timed_out);
        pix_q.delete();
        pix_last_q.delete();
    endtask

    initial begin
        int unsigned seed_val;
        int          bp_flag;
        seed_val   = $urandom(32'h81d2);
        reset      = 1'b1;
        i_valid    = 1'b0;
        i_last     = 1'b0;
        o_ready    = 1'b0;
        bp_on      = 1'b0;
        timed_out  = 1'b0;
        file_error = 1'b0;
        foreach (i_data[ch]) begin
            i_data[ch] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/maxpool2d_stimulus.txt", "r");
        if (fd == 0) begin
            file_error = 1'b1;
            $display("could not open the stimulus file");
        end
        while ((fd != 0) && !timed_out && !file_error && ($fscanf(fd, "%s", tag) == 1)) begin
            if (tag == "#") begin
                void'($fgets(line, fd));
            end else if (tag == "T") begin
                void'($fscanf(fd, "%s %d", test_name, bp_flag));
                bp_on <= (bp_flag != 0);
            end else if (tag == "I") begin
                read_input_row();
            end else if (tag == "E") begin
                read_expected_row();
            end else if (tag == "D") begin
                run_test();
            end else begin
                file_error = 1'b1;
                $display("stimulus file holds an unknown record type");
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests %0d, failed %0d, results %0d, errors %0d, assertion failures %0d",
                 u_chk.tests_run, u_chk.tests_failed, u_chk.total_checks,
                 u_chk.total_errors, dut.u_assert.fail_count);
        if (file_error || timed_out || (u_chk.tests_run == 0) || (u_chk.tests_failed != 0)
                || (dut.u_assert.fail_count != 0)) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

/* tb/maxpool2d_stimulus.txt */
# T name backpressure | I row: 5 pixels of ch0 ch1 ch2 hex, then i_last on final pixel
# E band: 2 columns of ch0 ch1 ch2 hex, then o_last on final column | D runs the test
T pos_image 0
I 00010000 00100000 00000001 00030000 00000010 00000002 00020000 00000020 00000003
  00008000 00000030 00000004 00070000 7fffffff 00000005 0
I 00020000 00000040 00000006 00018000 00000050 00000007 00050000 00200000 00000008
  00048000 00000060 00000009 00060000 00000001 0000000a 0
I 00000100 00000011 0000000b 00000200 00000022 0000000c 00000300 00000033 0000000d
  00000400 00000044 0000000e 00090000 00000055 0000000f 0
I 00000500 00000066 00000010 00000050 00300000 00000011 00000600 00000077 00000012
  00000700 00000088 00000013 00080000 00000099 00000014 1
E 00030000 00100000 00000007 00050000 00200000 00000009 0
E 00000500 00300000 00000011 00000700 00000088 00000013 1
D
T neg_image 0
I ffff0000 80000000 ffffff00 fffe0000 80000001 fffffff0 fffd0000 80000002 ffff0000
  fffc0000 80000003 fff00000 ffff8000 80000004 80000000 0
I fff00000 80000005 fffffff1 ffff4000 80000006 ffffff01 fffc8000 80000007 ff000000
  fff80000 80000008 fffe0000 ffffffff 80000009 80000000 1
E ffff4000 80000006 fffffff1 fffd0000 80000008 ffff0000 1
D
T discard_col 0
I 00000001 00000010 00000100 00000002 00000020 00000200 00000003 00000030 00000300
  00000004 00000040 00000400 7fffffff 7fffffff 7fffffff 0
I 00000005 00000050 00000500 00000006 00000060 00000600 00000007 00000070 00000700
  00000008 00000080 00000800 7fffffff 7fffffff 7fffffff 1
E 00000006 00000060 00000600 00000008 00000080 00000800 1
D
T backpressure 1
I 00010000 00100000 00000001 00030000 00000010 00000002 00020000 00000020 00000003
  00008000 00000030 00000004 00070000 7fffffff 00000005 0
I 00020000 00000040 00000006 00018000 00000050 00000007 00050000 00200000 00000008
  00048000 00000060 00000009 00060000 00000001 0000000a 0
I 00000100 00000011 0000000b 00000200 00000022 0000000c 00000300 00000033 0000000d
  00000400 00000044 0000000e 00090000 00000055 0000000f 0
I 00000500 00000066 00000010 00000050 00300000 00000011 00000600 00000077 00000012
  00000700 00000088 00000013 00080000 00000099 00000014 1
E 00030000 00100000 00000007 00050000 00200000 00000009 0
E 00000500 00300000 00000011 00000700 00000088 00000013 1
D
T back_to_back 0
I 00500000 00500000 00500000 00400000 00400000 00400000 00300000 00300000 00300000
  00200000 00200000 00200000 00100000 00100000 00100000 0
I 00010000 00020000 00030000 00040000 00050000 00060000 00070000 00080000 00090000
  000a0000 000b0000 000c0000 00000000 00000000 00000000 1
I 00000001 ffffffff 00000003 00000002 fffffffe 00000004 00000005 fffffff0 00000001
  00000006 ffffffe0 00000002 00000009 00000009 00000009 0
I 00000000 fffffffd 00000000 00000001 fffffffc 00000001 00000004 ffffff00 00000000
  00000003 fffffff8 00000000 00000009 00000009 00000009 1
E 00500000 00500000 00500000 00300000 00300000 00300000 1
E 00000002 ffffffff 00000004 00000006 fffffff8 00000002 1
D

/* maxpool2d.f */
hw/maxpool_pkg.sv
hw/pool_lane_if.sv
hw/line_ram.sv
hw/pool_ctrl.sv
hw/pool_lane.sv
hw/maxpool2d.sv
tb/maxpool2d_assert.sv
tb/maxpool2d_checker.sv
tb/tb_maxpool2d.sv

/* Bender.yml */
package:
  name: maxpool2d

sources:
  - files:
      - hw/maxpool_pkg.sv
      - hw/pool_lane_if.sv
      - hw/line_ram.sv
      - hw/pool_ctrl.sv
      - hw/pool_lane.sv
      - hw/maxpool2d.sv
  - target: test
    files:
      - tb/maxpool2d_assert.sv
      - tb/maxpool2d_checker.sv
      - tb/tb_maxpool2d.sv
